//--- source/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

	// instruction word size
	localparam int instr_width = 32;

	// primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		r_type  = 6'h00,
		branchs = 6'h01,
		j       = 6'h02,
		jal     = 6'h03,
		beq     = 6'h04,
		bne     = 6'h05,
		blez    = 6'h06,
		bgtz    = 6'h07,
		addi    = 6'h08,
		addiu   = 6'h09,
		slti    = 6'h0a,
		sltiu   = 6'h0b,
		andi    = 6'h0c,
		ori     = 6'h0d,
		xori    = 6'h0e,
		lui     = 6'h0f,
		cop0    = 6'h10,
		lb      = 6'h20,
		lh      = 6'h21,
		lw      = 6'h23,
		lbu     = 6'h24,
		lhu     = 6'h25,
		sb      = 6'h28,
		sh      = 6'h29,
		sw      = 6'h2b
	} opcode_t;

	// r-type function field, bits 5:0
	typedef enum logic [5:0] {
		sll   = 6'h00,
		srl   = 6'h02,
		sra   = 6'h03,
		sllv  = 6'h04,
		srlv  = 6'h06,
		srav  = 6'h07,
		jr    = 6'h08,
		jalr  = 6'h09,
		mfhi  = 6'h10,
		mthi  = 6'h11,
		mflo  = 6'h12,
		mtlo  = 6'h13,
		mult  = 6'h18,
		multu = 6'h19,
		div   = 6'h1a,
		divu  = 6'h1b,
		add   = 6'h20,
		addu  = 6'h21,
		sub   = 6'h22,
		subu  = 6'h23,
		and_f = 6'h24,
		or_f  = 6'h25,
		xor_f = 6'h26,
		nor_f = 6'h27,
		slt   = 6'h2a,
		sltu  = 6'h2b
	} funct_t;

	// rt field inside the regimm group
	typedef enum logic [4:0] {
		bltz   = 5'h00,
		bgez   = 5'h01,
		bltzal = 5'h10,
		bgezal = 5'h11
	} regimm_t;

	// rs field under cop0
	typedef enum logic [4:0] {
		mfc0 = 5'h00,
		mtc0 = 5'h04,
		eret = 5'h10
	} cop0_rs_t;

	// dst_ra means register 31
	typedef enum logic [1:0] {
		dst_rt = 2'b00,
		dst_rd = 2'b01,
		dst_ra = 2'b10
	} reg_dst_t;

	typedef enum logic [1:0] {
		src_alu = 2'b00,
		src_mem = 2'b01,
		src_cp0 = 2'b10
	} write_src_t;

	// alu_none doubles as the bubble value
	typedef enum logic [4:0] {
		alu_none,
		alu_add,
		alu_addu,
		alu_sub,
		alu_subu,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui,
		alu_mult,
		alu_multu,
		alu_div,
		alu_divu,
		alu_link
	} alu_op_t;

endpackage

`default_nettype wire

//--- source/instr_latch.sv
`timescale 1ns/100ps
`default_nettype none

module instr_latch (
	input  wire logic                                    clk,
	input  wire logic                                    rst,
	input  wire logic [mips_decode_pkg::instr_width-1:0] instr,
	input  wire logic                                    instr_valid,
	input  wire logic                                    stall,
	input  wire logic                                    flush,
	output mips_decode_pkg::opcode_t                     op_code,
	output logic [4:0]                                   rs,
	output logic [4:0]                                   rt,
	output logic [4:0]                                   rd,
	output logic [4:0]                                   shamt,
	output mips_decode_pkg::funct_t                      funct,
	output logic [15:0]                                  imm16,
	output logic                                         id_valid
);
	import mips_decode_pkg::*;

	// held instruction word
	logic [instr_width-1:0] instr_q;

	// flush beats stall and stall beats load
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			id_valid <= 1'b0;
		end else if (!stall) begin
			id_valid <= instr_valid;
		end
	end

	// word only moves on a real strobe
	always_ff @(posedge clk) begin
		if (!stall && instr_valid) begin
			instr_q <= instr;
		end
	end

	// field split
	assign op_code = opcode_t'(instr_q[31:26]);
	assign rs      = instr_q[25:21];
	assign rt      = instr_q[20:16];
	assign rd      = instr_q[15:11];
	assign shamt   = instr_q[10:6];
	assign funct   = funct_t'(instr_q[5:0]);
	assign imm16   = instr_q[15:0];

	// fetch side relies on the word staying put across a stall
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		(stall && !flush) |=> ($stable(instr_q) && $stable(id_valid)));

endmodule

`default_nettype wire

//--- source/main_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module main_decoder (
	input  mips_decode_pkg::opcode_t    op_code,
	input  wire logic [4:0]             rs,
	input  wire logic [4:0]             rt,
	input  mips_decode_pkg::funct_t     funct,
	output logic                        reg_write_en,
	output mips_decode_pkg::reg_dst_t   reg_dst,
	output logic                        alu_src_pc,
	output logic                        alu_src_imm,
	output mips_decode_pkg::write_src_t write_src,
	output logic                        hilo_read,
	output logic                        hilo_write_en,
	output logic                        branch,
	output logic                        unsign_extend,
	output logic                        jump,
	output logic                        cp0_write_en,
	output logic                        ri
);
	import mips_decode_pkg::*;

	always_comb begin
		// everything off, rt destination, alu result
		reg_write_en  = 1'b0;
		reg_dst       = dst_rt;
		alu_src_pc    = 1'b0;
		alu_src_imm   = 1'b0;
		write_src     = src_alu;
		hilo_read     = 1'b0;
		hilo_write_en = 1'b0;
		branch        = 1'b0;
		unsign_extend = 1'b0;
		jump          = 1'b0;
		cp0_write_en  = 1'b0;
		ri            = 1'b0;

		case (op_code)
			r_type: begin
				case (funct)
					// hi/lo moves
					mthi, mtlo: begin
						hilo_read     = 1'b1;
						hilo_write_en = 1'b1;
					end
					mfhi, mflo: begin
						reg_write_en = 1'b1;
						reg_dst      = dst_rd;
						hilo_read    = 1'b1;
					end
					mult, multu, div, divu: begin
						reg_write_en  = 1'b1;
						reg_dst       = dst_rd;
						hilo_write_en = 1'b1;
					end
					jr: jump = 1'b1;
					// link address comes through the alu from pc
					jalr: begin
						reg_write_en = 1'b1;
						reg_dst      = dst_rd;
						alu_src_pc   = 1'b1;
						jump         = 1'b1;
					end
					sll, srl, sra, sllv, srlv, srav,
					add, addu, sub, subu,
					and_f, or_f, xor_f, nor_f, slt, sltu: begin
						reg_write_en = 1'b1;
						reg_dst      = dst_rd;
					end
					default: ri = 1'b1;
				endcase
			end
			addi, addiu, slti, sltiu: begin
				reg_write_en = 1'b1;
				alu_src_imm  = 1'b1;
			end
			// logical immediates zero extend
			andi, ori, xori, lui: begin
				reg_write_en  = 1'b1;
				alu_src_imm   = 1'b1;
				unsign_extend = 1'b1;
			end
			lb, lh, lw, lbu, lhu: begin
				reg_write_en = 1'b1;
				alu_src_imm  = 1'b1;
				write_src    = src_mem;
			end
			sb, sh, sw: alu_src_imm = 1'b1;
			beq, bne, blez, bgtz: branch = 1'b1;
			branchs: begin
				case (regimm_t'(rt))
					bltz, bgez: branch = 1'b1;
					bltzal, bgezal: begin
						reg_write_en = 1'b1;
						reg_dst      = dst_ra;
						alu_src_pc   = 1'b1;
						branch       = 1'b1;
					end
					default: ri = 1'b1;
				endcase
			end
			j: jump = 1'b1;
			jal: begin
				reg_write_en = 1'b1;
				reg_dst      = dst_ra;
				alu_src_pc   = 1'b1;
				jump         = 1'b1;
			end
			cop0: begin
				case (cop0_rs_t'(rs))
					mfc0: begin
						reg_write_en = 1'b1;
						reg_dst      = dst_rt;
						write_src    = src_cp0;
					end
					mtc0, eret: cp0_write_en = 1'b1;
					default: ri = 1'b1;
				endcase
			end
			default: ri = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- source/alu_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module alu_decoder (
	input  mips_decode_pkg::opcode_t op_code,
	input  wire logic [4:0]          rt,
	input  mips_decode_pkg::funct_t  funct,
	output mips_decode_pkg::alu_op_t alu_op
);
	import mips_decode_pkg::*;

	// r-type operation from funct
	alu_op_t r_op;

	always_comb begin
		case (funct)
			add:   r_op = alu_add;
			addu:  r_op = alu_addu;
			sub:   r_op = alu_sub;
			subu:  r_op = alu_subu;
			and_f: r_op = alu_and;
			or_f:  r_op = alu_or;
			xor_f: r_op = alu_xor;
			nor_f: r_op = alu_nor;
			slt:   r_op = alu_slt;
			sltu:  r_op = alu_sltu;
			// variable shifts reuse the fixed ones
			sll, sllv: r_op = alu_sll;
			srl, srlv: r_op = alu_srl;
			sra, srav: r_op = alu_sra;
			mult:  r_op = alu_mult;
			multu: r_op = alu_multu;
			div:   r_op = alu_div;
			divu:  r_op = alu_divu;
			jalr:  r_op = alu_link;
			// jr, hi/lo moves, unlisted
			default: r_op = alu_none;
		endcase
	end

	always_comb begin
		case (op_code)
			r_type: alu_op = r_op;
			addi:   alu_op = alu_add;
			addiu:  alu_op = alu_addu;
			slti:   alu_op = alu_slt;
			sltiu:  alu_op = alu_sltu;
			andi:   alu_op = alu_and;
			ori:    alu_op = alu_or;
			xori:   alu_op = alu_xor;
			lui:    alu_op = alu_lui;
			// address add for memory access
			lb, lh, lw, lbu, lhu, sb, sh, sw: alu_op = alu_addu;
			jal:    alu_op = alu_link;
			branchs: begin
				// only the linking branches use the alu
				if (rt == bltzal || rt == bgezal) begin
					alu_op = alu_link;
				end else begin
					alu_op = alu_none;
				end
			end
			default: alu_op = alu_none;
		endcase
	end

endmodule

`default_nettype wire

//--- source/decode_stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_reg (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        stall,
	input  wire logic                        flush,
	input  wire logic                        id_valid,
	input  wire logic                        reg_write_en,
	input  mips_decode_pkg::reg_dst_t        reg_dst,
	input  wire logic                        alu_src_pc,
	input  wire logic                        alu_src_imm,
	input  mips_decode_pkg::write_src_t      write_src,
	input  wire logic                        hilo_read,
	input  wire logic                        hilo_write_en,
	input  wire logic                        branch,
	input  wire logic                        unsign_extend,
	input  wire logic                        jump,
	input  wire logic                        cp0_write_en,
	input  wire logic                        ri,
	input  mips_decode_pkg::alu_op_t         alu_op,
	input  wire logic [4:0]                  rs,
	input  wire logic [4:0]                  rt,
	input  wire logic [4:0]                  rd,
	input  wire logic [4:0]                  shamt,
	input  wire logic [15:0]                 imm16,
	output logic                             ex_valid,
	output logic                             ex_reg_write_en,
	output mips_decode_pkg::reg_dst_t        ex_reg_dst,
	output logic                             ex_alu_src_pc,
	output logic                             ex_alu_src_imm,
	output mips_decode_pkg::write_src_t      ex_write_src,
	output logic                             ex_hilo_read,
	output logic                             ex_hilo_write_en,
	output logic                             ex_branch,
	output logic                             ex_unsign_extend,
	output logic                             ex_jump,
	output logic                             ex_cp0_write_en,
	output logic                             ex_ri,
	output mips_decode_pkg::alu_op_t         ex_alu_op,
	output logic [4:0]                       ex_rs,
	output logic [4:0]                       ex_rt,
	output logic [4:0]                       ex_rd,
	output logic [4:0]                       ex_shamt,
	output logic [15:0]                      ex_imm16
);
	import mips_decode_pkg::*;

	// bubble on reset, flush, or an empty id slot
	logic bubble;

	assign bubble = rst || flush || (!stall && !id_valid);

	always_ff @(posedge clk) begin
		if (bubble) begin
			ex_valid         <= 1'b0;
			ex_reg_write_en  <= 1'b0;
			ex_reg_dst       <= dst_rt;
			ex_alu_src_pc    <= 1'b0;
			ex_alu_src_imm   <= 1'b0;
			ex_write_src     <= src_alu;
			ex_hilo_read     <= 1'b0;
			ex_hilo_write_en <= 1'b0;
			ex_branch        <= 1'b0;
			ex_unsign_extend <= 1'b0;
			ex_jump          <= 1'b0;
			ex_cp0_write_en  <= 1'b0;
			ex_ri            <= 1'b0;
			ex_alu_op        <= alu_none;
		end else if (!stall) begin
			ex_valid         <= 1'b1;
			ex_reg_write_en  <= reg_write_en;
			ex_reg_dst       <= reg_dst;
			ex_alu_src_pc    <= alu_src_pc;
			ex_alu_src_imm   <= alu_src_imm;
			ex_write_src     <= write_src;
			ex_hilo_read     <= hilo_read;
			ex_hilo_write_en <= hilo_write_en;
			ex_branch        <= branch;
			ex_unsign_extend <= unsign_extend;
			ex_jump          <= jump;
			ex_cp0_write_en  <= cp0_write_en;
			ex_ri            <= ri;
			ex_alu_op        <= alu_op;
		end
	end

	// register fields ride along with the word
	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_rs    <= rs;
			ex_rt    <= rt;
			ex_rd    <= rd;
			ex_shamt <= shamt;
			ex_imm16 <= imm16;
		end
	end

	// a reserved word must never reach write back
	a_ri_no_write: assert property (@(posedge clk) disable iff (rst)
		!(ex_ri && ex_reg_write_en));

	// flushed slot is empty next cycle
	a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
		flush |=> !ex_valid);

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
	input  wire logic                                    clk,
	input  wire logic                                    rst,
	input  wire logic [mips_decode_pkg::instr_width-1:0] instr,
	input  wire logic                                    instr_valid,
	input  wire logic                                    stall,
	input  wire logic                                    flush,
	output logic                                         ex_valid,
	output logic                                         ex_reg_write_en,
	output mips_decode_pkg::reg_dst_t                    ex_reg_dst,
	output logic                                         ex_alu_src_pc,
	output logic                                         ex_alu_src_imm,
	output mips_decode_pkg::write_src_t                  ex_write_src,
	output logic                                         ex_hilo_read,
	output logic                                         ex_hilo_write_en,
	output logic                                         ex_branch,
	output logic                                         ex_unsign_extend,
	output logic                                         ex_jump,
	output logic                                         ex_cp0_write_en,
	output logic                                         ex_ri,
	output mips_decode_pkg::alu_op_t                     ex_alu_op,
	output logic [4:0]                                   ex_rs,
	output logic [4:0]                                   ex_rt,
	output logic [4:0]                                   ex_rd,
	output logic [4:0]                                   ex_shamt,
	output logic [15:0]                                  ex_imm16
);
	import mips_decode_pkg::*;

	// id stage fields
	opcode_t     op_code;
	funct_t      funct;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  shamt;
	logic [15:0] imm16;
	logic        id_valid;

	// decoded controls
	logic        reg_write_en;
	reg_dst_t    reg_dst;
	logic        alu_src_pc;
	logic        alu_src_imm;
	write_src_t  write_src;
	logic        hilo_read;
	logic        hilo_write_en;
	logic        branch;
	logic        unsign_extend;
	logic        jump;
	logic        cp0_write_en;
	logic        ri;
	alu_op_t     alu_op;

	instr_latch u_latch (
		.clk(clk), .rst(rst), .instr(instr), .instr_valid(instr_valid),
		.stall(stall), .flush(flush), .op_code(op_code), .rs(rs), .rt(rt),
		.rd(rd), .shamt(shamt), .funct(funct), .imm16(imm16), .id_valid(id_valid)
	);

	main_decoder u_main_dec (
		.op_code(op_code), .rs(rs), .rt(rt), .funct(funct),
		.reg_write_en(reg_write_en), .reg_dst(reg_dst), .alu_src_pc(alu_src_pc),
		.alu_src_imm(alu_src_imm), .write_src(write_src), .hilo_read(hilo_read),
		.hilo_write_en(hilo_write_en), .branch(branch), .unsign_extend(unsign_extend),
		.jump(jump), .cp0_write_en(cp0_write_en), .ri(ri)
	);

	alu_decoder u_alu_dec (
		.op_code(op_code), .rt(rt), .funct(funct), .alu_op(alu_op)
	);

	// id/ex boundary
	decode_stage_reg u_id_ex (
		.clk(clk), .rst(rst), .stall(stall), .flush(flush), .id_valid(id_valid),
		.reg_write_en(reg_write_en), .reg_dst(reg_dst), .alu_src_pc(alu_src_pc),
		.alu_src_imm(alu_src_imm), .write_src(write_src), .hilo_read(hilo_read),
		.hilo_write_en(hilo_write_en), .branch(branch), .unsign_extend(unsign_extend),
		.jump(jump), .cp0_write_en(cp0_write_en), .ri(ri), .alu_op(alu_op),
		.rs(rs), .rt(rt), .rd(rd), .shamt(shamt), .imm16(imm16),
		.ex_valid(ex_valid), .ex_reg_write_en(ex_reg_write_en),
		.ex_reg_dst(ex_reg_dst), .ex_alu_src_pc(ex_alu_src_pc),
		.ex_alu_src_imm(ex_alu_src_imm), .ex_write_src(ex_write_src),
		.ex_hilo_read(ex_hilo_read), .ex_hilo_write_en(ex_hilo_write_en),
		.ex_branch(ex_branch), .ex_unsign_extend(ex_unsign_extend),
		.ex_jump(ex_jump), .ex_cp0_write_en(ex_cp0_write_en), .ex_ri(ex_ri),
		.ex_alu_op(ex_alu_op), .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
		.ex_shamt(ex_shamt), .ex_imm16(ex_imm16)
	);

endmodule

`default_nettype wire

//--- bench/tb_decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_unit;
	import mips_decode_pkg::*;

	// words per phase
	localparam int n_dir   = 192;
	localparam int n_rand  = 200;
	localparam int n_stall = 300;
	localparam int n_flush = 120;
	// stalled and gapped phases take about two cycles a word
	localparam int stim_cycles   = 8 + n_dir + n_rand + 2 * (n_stall + n_flush) + 32;
	localparam int timeout_limit = 4 * stim_cycles;

	// expected control bundle as plain vectors
	typedef struct packed {
		logic       reg_write_en;
		logic [1:0] reg_dst;
		logic       alu_src_pc;
		logic       alu_src_imm;
		logic [1:0] write_src;
		logic       hilo_read;
		logic       hilo_write_en;
		logic       branch;
		logic       unsign_extend;
		logic       jump;
		logic       cp0_write_en;
		logic       ri;
		logic [4:0] alu_op;
	} ctl_t;

	// word in flight with its accept cycle and stall count
	typedef struct packed {
		logic [31:0] word;
		logic [31:0] cyc;
		logic [31:0] stl;
	} pend_t;

	logic        clk;
	logic        rst;
	logic [31:0] instr;
	logic        instr_valid;
	logic        stall;
	logic        flush;

	logic        ex_valid;
	logic        ex_reg_write_en;
	reg_dst_t    ex_reg_dst;
	logic        ex_alu_src_pc;
	logic        ex_alu_src_imm;
	write_src_t  ex_write_src;
	logic        ex_hilo_read;
	logic        ex_hilo_write_en;
	logic        ex_branch;
	logic        ex_unsign_extend;
	logic        ex_jump;
	logic        ex_cp0_write_en;
	logic        ex_ri;
	alu_op_t     ex_alu_op;
	logic [4:0]  ex_rs;
	logic [4:0]  ex_rt;
	logic [4:0]  ex_rd;
	logic [4:0]  ex_shamt;
	logic [15:0] ex_imm16;

	logic [31:0] stim_q[$];
	pend_t       exp_q[$];
	// word that currently sits in the ex slot
	logic [31:0] last_word   = '0;
	int unsigned cycle       = 0;
	int unsigned stall_cnt   = 0;
	int unsigned error_count = 0;
	int unsigned check_count = 0;
	logic        prev_stall  = 1'b0;
	logic        prev_flush  = 1'b0;

	decode_unit i_dut (.*);

	always #5 clk = ~clk;

	// rule tables giving control fields and alu operation
	function automatic ctl_t expected_controls(input logic [31:0] w);
		ctl_t c;
		c = '0;
		case (w[31:26])
			r_type: begin
				case (w[5:0])
					mthi, mtlo: begin
						c.hilo_read = 1'b1;
						c.hilo_write_en = 1'b1;
					end
					mfhi, mflo: begin
						c.reg_write_en = 1'b1;
						c.reg_dst = dst_rd;
						c.hilo_read = 1'b1;
					end
					mult, multu, div, divu: begin
						c.reg_write_en = 1'b1;
						c.reg_dst = dst_rd;
						c.hilo_write_en = 1'b1;
					end
					jr: c.jump = 1'b1;
					jalr: begin
						c.reg_write_en = 1'b1;
						c.reg_dst = dst_rd;
						c.alu_src_pc = 1'b1;
						c.jump = 1'b1;
					end
					sll, srl, sra, sllv, srlv, srav, add, addu, sub, subu,
					and_f, or_f, xor_f, nor_f, slt, sltu: begin
						c.reg_write_en = 1'b1;
						c.reg_dst = dst_rd;
					end
					default: c.ri = 1'b1;
				endcase
				// r-type alu from funct
				case (w[5:0])
					add: c.alu_op = alu_add;
					addu: c.alu_op = alu_addu;
					sub: c.alu_op = alu_sub;
					subu: c.alu_op = alu_subu;
					and_f: c.alu_op = alu_and;
					or_f: c.alu_op = alu_or;
					xor_f: c.alu_op = alu_xor;
					nor_f: c.alu_op = alu_nor;
					slt: c.alu_op = alu_slt;
					sltu: c.alu_op = alu_sltu;
					sll, sllv: c.alu_op = alu_sll;
					srl, srlv: c.alu_op = alu_srl;
					sra, srav: c.alu_op = alu_sra;
					mult: c.alu_op = alu_mult;
					multu: c.alu_op = alu_multu;
					div: c.alu_op = alu_div;
					divu: c.alu_op = alu_divu;
					jalr: c.alu_op = alu_link;
					default: c.alu_op = alu_none;
				endcase
			end
			addi, addiu, slti, sltiu: begin
				c.reg_write_en = 1'b1;
				c.alu_src_imm = 1'b1;
			end
			andi, ori, xori, lui: begin
				c.reg_write_en = 1'b1;
				c.alu_src_imm = 1'b1;
				c.unsign_extend = 1'b1;
			end
			lb, lh, lw, lbu, lhu: begin
				c.reg_write_en = 1'b1;
				c.alu_src_imm = 1'b1;
				c.write_src = src_mem;
			end
			sb, sh, sw: c.alu_src_imm = 1'b1;
			beq, bne, blez, bgtz: c.branch = 1'b1;
			branchs: begin
				case (w[20:16])
					bltz, bgez: c.branch = 1'b1;
					bltzal, bgezal: begin
						c.reg_write_en = 1'b1;
						c.reg_dst = dst_ra;
						c.alu_src_pc = 1'b1;
						c.branch = 1'b1;
						c.alu_op = alu_link;
					end
					default: c.ri = 1'b1;
				endcase
			end
			j: c.jump = 1'b1;
			jal: begin
				c.reg_write_en = 1'b1;
				c.reg_dst = dst_ra;
				c.alu_src_pc = 1'b1;
				c.jump = 1'b1;
			end
			cop0: begin
				case (w[25:21])
					mfc0: begin
						c.reg_write_en = 1'b1;
						c.write_src = src_cp0;
					end
					mtc0, eret: c.cp0_write_en = 1'b1;
					default: c.ri = 1'b1;
				endcase
			end
			default: c.ri = 1'b1;
		endcase
		// alu for the immediate, memory and jump groups
		case (w[31:26])
			addi: c.alu_op = alu_add;
			addiu: c.alu_op = alu_addu;
			slti: c.alu_op = alu_slt;
			sltiu: c.alu_op = alu_sltu;
			andi: c.alu_op = alu_and;
			ori: c.alu_op = alu_or;
			xori: c.alu_op = alu_xor;
			lui: c.alu_op = alu_lui;
			lb, lh, lw, lbu, lhu, sb, sh, sw: c.alu_op = alu_addu;
			jal: c.alu_op = alu_link;
			default: ;
		endcase
		return c;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp_v);
		check_count++;
		if (got !== exp_v) begin
			$display("CHECK FAILED %s got %h expected %h at cycle %0d",
				name, got, exp_v, cycle);
			error_count++;
		end
	endtask

	task automatic compare_controls(input ctl_t e);
		check_value("ex_reg_write_en", 32'(ex_reg_write_en), 32'(e.reg_write_en));
		check_value("ex_reg_dst", 32'(ex_reg_dst), 32'(e.reg_dst));
		check_value("ex_alu_src_pc", 32'(ex_alu_src_pc), 32'(e.alu_src_pc));
		check_value("ex_alu_src_imm", 32'(ex_alu_src_imm), 32'(e.alu_src_imm));
		check_value("ex_write_src", 32'(ex_write_src), 32'(e.write_src));
		check_value("ex_hilo_read", 32'(ex_hilo_read), 32'(e.hilo_read));
		check_value("ex_hilo_write_en", 32'(ex_hilo_write_en), 32'(e.hilo_write_en));
		check_value("ex_branch", 32'(ex_branch), 32'(e.branch));
		check_value("ex_unsign_extend", 32'(ex_unsign_extend), 32'(e.unsign_extend));
		check_value("ex_jump", 32'(ex_jump), 32'(e.jump));
		check_value("ex_cp0_write_en", 32'(ex_cp0_write_en), 32'(e.cp0_write_en));
		check_value("ex_ri", 32'(ex_ri), 32'(e.ri));
		check_value("ex_alu_op", 32'(ex_alu_op), 32'(e.alu_op));
	endtask

	// controls and passed-through fields of one word
	task automatic compare_word(input logic [31:0] w);
		compare_controls(expected_controls(w));
		check_value("ex_rs", 32'(ex_rs), 32'(w[25:21]));
		check_value("ex_rt", 32'(ex_rt), 32'(w[20:16]));
		check_value("ex_rd", 32'(ex_rd), 32'(w[15:11]));
		check_value("ex_shamt", 32'(ex_shamt), 32'(w[10:6]));
		check_value("ex_imm16", 32'(ex_imm16), 32'(w[15:0]));
	endtask

	// every opcode, then every funct, regimm rt and cop0 rs
	task automatic queue_encodings();
		logic [31:0] w;
		for (int op = 0; op < 64; op++) begin
			w = $urandom;
			w[31:26] = op[5:0];
			stim_q.push_back(w);
		end
		for (int k = 0; k < 64; k++) begin
			w = $urandom;
			w[31:26] = r_type;
			w[5:0] = k[5:0];
			stim_q.push_back(w);
		end
		for (int k = 0; k < 32; k++) begin
			w = $urandom;
			w[31:26] = branchs;
			w[20:16] = k[4:0];
			stim_q.push_back(w);
		end
		for (int k = 0; k < 32; k++) begin
			w = $urandom;
			w[31:26] = cop0;
			w[25:21] = k[4:0];
			stim_q.push_back(w);
		end
	endtask

	// half of them with a low opcode so listed encodings show up
	task automatic queue_random(input int n, input bit low_ops);
		logic [31:0] w;
		for (int k = 0; k < n; k++) begin
			w = $urandom;
			if (low_ops && ($urandom % 2) != 0) begin
				w[31:26] = 6'($urandom % 16);
			end
			stim_q.push_back(w);
		end
	endtask

	// plays fetch and hazard side until stim_q is used up
	task automatic run_words(input int stall_pct, input int gap_pct, input int flush_pct);
		logic pending;
		pending = 1'b0;
		while (stim_q.size() != 0 || pending) begin
			@(posedge clk);
			// a stalled word stays on the bus
			if (!(instr_valid && stall && !flush)) begin
				if (stim_q.size() != 0 && ($urandom % 100) >= gap_pct) begin
					instr <= stim_q.pop_front();
					instr_valid <= 1'b1;
					pending = 1'b1;
				end else begin
					instr_valid <= 1'b0;
					pending = 1'b0;
				end
			end
			stall <= (($urandom % 100) < stall_pct);
			flush <= (($urandom % 100) < flush_pct);
		end
	endtask

	// scoreboard on the ex side
	always @(posedge clk) begin
		pend_t p;
		if (!rst) begin
			if (prev_flush && ex_valid) begin
				$display("ERROR: ex_valid still high the cycle after a flush, cycle %0d", cycle);
				error_count++;
			end
			if (!ex_valid) begin
				// gap or bubble carries no control
				compare_controls('0);
			end else if (prev_stall) begin
				// slot held through the stall
				compare_word(last_word);
			end else if (exp_q.size() == 0) begin
				$display("ERROR: ex_valid high with no word in flight, cycle %0d", cycle);
				error_count++;
			end else begin
				p = exp_q.pop_front();
				last_word = p.word;
				compare_word(p.word);
				// two cycles plus one per stall
				check_value("latency", cycle - p.cyc, 32'd2 + stall_cnt - p.stl);
			end
			if (stall) begin
				stall_cnt++;
			end
			// flush drops both stages
			if (flush) begin
				exp_q.delete();
			end else if (instr_valid && !stall) begin
				p.word = instr;
				p.cyc = cycle;
				p.stl = stall_cnt;
				exp_q.push_back(p);
			end
		end
		prev_stall = stall;
		prev_flush = flush;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_limit) begin
			$display("timeout after %0d cycles, checks %0d errors %0d",
				timeout_limit, check_count, error_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h64ebb739));
		clk = 1'b0;
		rst <= 1'b1;
		instr <= '0;
		instr_valid <= 1'b0;
		stall <= 1'b0;
		flush <= 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		// state straight out of reset
		check_value("id_valid", 32'(i_dut.u_latch.id_valid), 32'd0);
		check_value("ex_valid", 32'(ex_valid), 32'd0);
		check_value("ex_reg_write_en", 32'(ex_reg_write_en), 32'd0);
		check_value("ex_hilo_write_en", 32'(ex_hilo_write_en), 32'd0);
		check_value("ex_cp0_write_en", 32'(ex_cp0_write_en), 32'd0);
		check_value("ex_branch", 32'(ex_branch), 32'd0);
		check_value("ex_jump", 32'(ex_jump), 32'd0);
		check_value("ex_ri", 32'(ex_ri), 32'd0);

		queue_encodings();
		run_words(0, 0, 0);
		queue_random(n_rand, 1'b0);
		run_words(0, 0, 0);
		queue_random(n_stall, 1'b1);
		run_words(30, 20, 0);
		queue_random(n_flush, 1'b1);
		run_words(10, 10, 10);

		@(posedge clk);
		instr_valid <= 1'b0;
		stall <= 1'b0;
		flush <= 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);

		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
source/mips_decode_pkg.sv
source/instr_latch.sv
source/main_decoder.sv
source/alu_decoder.sv
source/decode_stage_reg.sv
source/decode_unit.sv
bench/tb_decode_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_decode_unit
FILELIST  := compile.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
